// ==== hyper_ctrl.f ====
source/hyper_pkg.sv
source/hyper_fifo.sv
source/hyper_axi_frontend.sv
source/hyper_phy.sv
source/hyper_ctrl.sv
test/tb_clk_gen.sv
test/hyper_ram_model.sv
test/hyper_ctrl_assert.sv
test/tb_hyper_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the HyperBus controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hyper_ctrl \
    -Mdir build \
    -f hyper_ctrl.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./build/Vtb_hyper_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== source/hyper_axi_frontend.sv ====
// AXI-style front end, one transaction at a time
// Read-first arbitration, W forwarding, write response, read data

`timescale 1ns/1ps

module hyper_axi_frontend (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  hyper_pkg::axi_ax_t      aw_i,
    input  logic                    aw_valid_i,
    output logic                    aw_ready_o,
    input  hyper_pkg::axi_w_t       w_i,
    input  logic                    w_valid_i,
    output logic                    w_ready_o,
    output logic                    b_valid_o,
    input  logic                    b_ready_i,
    input  hyper_pkg::axi_ax_t      ar_i,
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    output hyper_pkg::axi_r_t       r_o,
    output logic                    r_valid_o,
    input  logic                    r_ready_i,
    output hyper_pkg::hyper_trans_t trans_o,
    output logic                    trans_valid_o,
    input  logic                    trans_ready_i,
    output hyper_pkg::tx_beat_t     tx_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    input  hyper_pkg::rx_beat_t     rx_i,
    input  logic                    rx_valid_i,
    output logic                    rx_ready_o,
    input  logic                    write_done_i
);

    import hyper_pkg::*;

    hyper_trans_t trans_q;
    logic         trans_open_q;  // From accept to B or last R beat
    logic         w_open_q;      // Still expecting W beats
    logic         rd_active;
    logic         aw_fire;
    logic         ar_fire;

    // A pending read blocks the write address
    assign ar_ready_o = !trans_open_q && !rx_valid_i;
    assign aw_ready_o = !trans_open_q && !ar_valid_i;
    assign ar_fire    = ar_valid_i && ar_ready_o;
    assign aw_fire    = aw_valid_i && aw_ready_o;

    assign trans_o    = trans_q;
    assign rd_active  = trans_open_q && !trans_q.write;

    // W beats go straight into the tx FIFO
    assign tx_o       = '{data: w_i.data, strb: w_i.strb};
    assign tx_valid_o = w_open_q && w_valid_i;
    assign w_ready_o  = w_open_q && tx_ready_i;

    assign r_o        = '{data: rx_i.data, last: rx_i.last};
    assign r_valid_o  = rd_active && rx_valid_i;
    assign rx_ready_o = rd_active && r_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trans_open_q  <= 1'b0;
            trans_valid_o <= 1'b0;
            w_open_q      <= 1'b0;
            b_valid_o     <= 1'b0;
        end else begin
            if (ar_fire || aw_fire) begin
                trans_open_q  <= 1'b1;
                trans_valid_o <= 1'b1;
            end else begin
                if (trans_valid_o && trans_ready_i) trans_valid_o <= 1'b0;
                if ((b_valid_o && b_ready_i) || (r_valid_o && r_ready_i && rx_i.last)) begin
                    trans_open_q <= 1'b0;
                end
            end

            if (aw_fire) begin
                w_open_q <= 1'b1;
            end else if (w_valid_i && w_ready_o && w_i.last) begin
                w_open_q <= 1'b0;
            end

            if (write_done_i) begin
                b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            trans_q <= '{write: 1'b0, addr: ar_i.addr, len: ar_i.len};
        end else if (aw_fire) begin
            trans_q <= '{write: 1'b1, addr: aw_i.addr, len: aw_i.len};
        end
    end

endmodule

// ==== source/hyper_ctrl.sv ====
// HyperBus controller top level
// Front end, tx and rx FIFOs and PHY

`timescale 1ns/1ps

module hyper_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  hyper_pkg::axi_ax_t  aw_i,
    input  logic                aw_valid_i,
    output logic                aw_ready_o,
    input  hyper_pkg::axi_w_t   w_i,
    input  logic                w_valid_i,
    output logic                w_ready_o,
    output logic                b_valid_o,
    input  logic                b_ready_i,
    input  hyper_pkg::axi_ax_t  ar_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    output hyper_pkg::axi_r_t   r_o,
    output logic                r_valid_o,
    input  logic                r_ready_i,
    output hyper_pkg::cs_t      hyper_cs_n_o,
    output logic                hyper_ck_o,
    output logic                hyper_ck_n_o,
    output logic                hyper_rwds_o,
    input  logic                hyper_rwds_i,
    output logic                hyper_rwds_oe_o,
    output logic [7:0]          hyper_dq_o,
    input  logic [7:0]          hyper_dq_i,
    output logic                hyper_dq_oe_o,
    output logic                hyper_reset_n_o
);

    import hyper_pkg::*;

    hyper_trans_t trans;
    logic         trans_valid;
    logic         trans_ready;
    tx_beat_t     fe_tx;         // Front end side of the tx FIFO
    logic         fe_tx_valid;
    logic         fe_tx_ready;
    tx_beat_t     phy_tx;
    logic         phy_tx_valid;
    logic         phy_tx_ready;
    rx_beat_t     phy_rx;
    logic         phy_rx_valid;
    logic         phy_rx_ready;
    rx_beat_t     fe_rx;
    logic         fe_rx_valid;
    logic         fe_rx_ready;
    logic         write_done;

    hyper_axi_frontend i_frontend (
        .clk_i         ( clk_i        ),
        .rst_n_i       ( rst_n_i      ),
        .aw_i          ( aw_i         ),
        .aw_valid_i    ( aw_valid_i   ),
        .aw_ready_o    ( aw_ready_o   ),
        .w_i           ( w_i          ),
        .w_valid_i     ( w_valid_i    ),
        .w_ready_o     ( w_ready_o    ),
        .b_valid_o     ( b_valid_o    ),
        .b_ready_i     ( b_ready_i    ),
        .ar_i          ( ar_i         ),
        .ar_valid_i    ( ar_valid_i   ),
        .ar_ready_o    ( ar_ready_o   ),
        .r_o           ( r_o          ),
        .r_valid_o     ( r_valid_o    ),
        .r_ready_i     ( r_ready_i    ),
        .trans_o       ( trans        ),
        .trans_valid_o ( trans_valid  ),
        .trans_ready_i ( trans_ready  ),
        .tx_o          ( fe_tx        ),
        .tx_valid_o    ( fe_tx_valid  ),
        .tx_ready_i    ( fe_tx_ready  ),
        .rx_i          ( fe_rx        ),
        .rx_valid_i    ( fe_rx_valid  ),
        .rx_ready_o    ( fe_rx_ready  ),
        .write_done_i  ( write_done   )
    );

    hyper_fifo #(.T(tx_beat_t), .DEPTH(FIFO_DEPTH)) i_tx_fifo (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .data_i  ( fe_tx        ),
        .valid_i ( fe_tx_valid  ),
        .ready_o ( fe_tx_ready  ),
        .data_o  ( phy_tx       ),
        .valid_o ( phy_tx_valid ),
        .ready_i ( phy_tx_ready )
    );

    hyper_fifo #(.T(rx_beat_t), .DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .data_i  ( phy_rx       ),
        .valid_i ( phy_rx_valid ),
        .ready_o ( phy_rx_ready ),
        .data_o  ( fe_rx        ),
        .valid_o ( fe_rx_valid  ),
        .ready_i ( fe_rx_ready  )
    );

    hyper_phy i_phy (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .trans_i         ( trans           ),
        .trans_valid_i   ( trans_valid     ),
        .trans_ready_o   ( trans_ready     ),
        .tx_i            ( phy_tx          ),
        .tx_valid_i      ( phy_tx_valid    ),
        .tx_ready_o      ( phy_tx_ready    ),
        .rx_o            ( phy_rx          ),
        .rx_valid_o      ( phy_rx_valid    ),
        .rx_ready_i      ( phy_rx_ready    ),
        .write_done_o    ( write_done      ),
        .hyper_cs_n_o    ( hyper_cs_n_o    ),
        .hyper_ck_o      ( hyper_ck_o      ),
        .hyper_ck_n_o    ( hyper_ck_n_o    ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_reset_n_o ( hyper_reset_n_o )
    );

endmodule

// ==== source/hyper_fifo.sv ====
// Synchronous valid/ready FIFO
// Element type and depth set by parameters

`timescale 1ns/1ps

module hyper_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16       // Power of two, pointers wrap freely
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  T     data_i,
    input  logic valid_i,
    output logic ready_o,
    output T     data_o,
    output logic valid_o,
    input  logic ready_i
);

    localparam int PTR_W = $clog2(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign ready_o = (count_q != (PTR_W+1)'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem[rd_ptr_q];
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr_q] <= data_i;
    end

endmodule

// ==== source/hyper_phy.sv ====
// HyperBus sequencer, single data rate
// Command/address, latency, data and recovery phases

`timescale 1ns/1ps

module hyper_phy (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  hyper_pkg::hyper_trans_t trans_i,
    input  logic                    trans_valid_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::tx_beat_t     tx_i,
    input  logic                    tx_valid_i,
    output logic                    tx_ready_o,
    output hyper_pkg::rx_beat_t     rx_o,
    output logic                    rx_valid_o,
    input  logic                    rx_ready_i,
    output logic                    write_done_o,
    output hyper_pkg::cs_t          hyper_cs_n_o,
    output logic                    hyper_ck_o,
    output logic                    hyper_ck_n_o,
    output logic                    hyper_rwds_o,
    input  logic                    hyper_rwds_i,
    output logic                    hyper_rwds_oe_o,
    input  logic [7:0]              hyper_dq_i,
    output logic [7:0]              hyper_dq_o,
    output logic                    hyper_dq_oe_o,
    output logic                    hyper_reset_n_o
);

    import hyper_pkg::*;

    phy_state_e            state_q;
    hyper_trans_t          trans_q;
    logic [CA_BYTES*8-1:0] ca_q;        // Shifts out MSB first
    logic [2:0]            byte_cnt_q;  // 0 is the cs setup cycle
    logic [3:0]            lat_cnt_q;   // Latency, then recovery
    burst_len_t            beat_cnt_q;
    logic                  lo_q;        // Low byte of the word is next
    logic [7:0]            rx_hi_q;
    logic                  ck_q;
    logic                  step;        // Bus clock advances this cycle
    logic                  byte_xfer;
    logic                  word_done;
    logic                  last_beat;
    logic                  cs_act;

    always_comb begin
        case (state_q)
            PHY_CA:      step = (byte_cnt_q != '0);
            PHY_LATENCY: step = 1'b1;
            PHY_WDATA:   step = tx_valid_i;  // Write pauses on an empty FIFO
            PHY_RDATA:   step = !rx_valid_o || rx_ready_i;
            default:     step = 1'b0;
        endcase
    end

    assign byte_xfer = step && ((state_q == PHY_WDATA) ||
                                (state_q == PHY_RDATA && hyper_rwds_i));
    assign word_done = byte_xfer && lo_q;
    assign last_beat = (beat_cnt_q == trans_q.len);

    assign cs_act = (state_q == PHY_CA) || (state_q == PHY_LATENCY) ||
                    (state_q == PHY_WDATA) || (state_q == PHY_RDATA);
    assign hyper_cs_n_o = cs_act ? ~(cs_t'(1) << trans_q.addr[ADDR_W-1]) : '1;

    assign trans_ready_o   = (state_q == PHY_IDLE);
    assign tx_ready_o      = (state_q == PHY_WDATA) && lo_q;  // Pop after the low byte
    assign hyper_ck_o      = ck_q ^ step;
    assign hyper_ck_n_o    = ~hyper_ck_o;
    assign hyper_dq_oe_o   = (state_q == PHY_CA && byte_cnt_q != '0) || (state_q == PHY_WDATA);
    assign hyper_rwds_oe_o = (state_q == PHY_WDATA);
    // rwds high masks the byte
    assign hyper_rwds_o    = hyper_rwds_oe_o && !(lo_q ? tx_i.strb[0] : tx_i.strb[1]);

    always_comb begin
        case (state_q)
            PHY_CA:    hyper_dq_o = ca_q[CA_BYTES*8-1 -: 8];
            PHY_WDATA: hyper_dq_o = lo_q ? tx_i.data[7:0] : tx_i.data[15:8];
            default:   hyper_dq_o = 8'h00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= PHY_IDLE;
            byte_cnt_q   <= '0;
            lat_cnt_q    <= '0;
            beat_cnt_q   <= '0;
            lo_q         <= 1'b0;
            ck_q         <= 1'b0;
            rx_valid_o   <= 1'b0;
            write_done_o <= 1'b0;
        end else begin
            write_done_o <= 1'b0;
            ck_q         <= ck_q ^ step;
            if (rx_valid_o && rx_ready_i) rx_valid_o <= 1'b0;
            if (byte_xfer) lo_q <= !lo_q;
            if (word_done) beat_cnt_q <= beat_cnt_q + 1'b1;

            case (state_q)
                PHY_IDLE: begin
                    if (trans_valid_i) begin
                        state_q    <= PHY_CA;
                        byte_cnt_q <= '0;
                        beat_cnt_q <= '0;
                        lo_q       <= 1'b0;
                    end
                end
                PHY_CA: begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 3'(CA_BYTES)) begin
                        state_q   <= PHY_LATENCY;
                        lat_cnt_q <= '0;
                    end
                end
                PHY_LATENCY: begin
                    lat_cnt_q <= lat_cnt_q + 1'b1;
                    if (lat_cnt_q == 4'(LATENCY_CYCLES - 1)) begin
                        state_q <= trans_q.write ? PHY_WDATA : PHY_RDATA;
                    end
                end
                PHY_WDATA, PHY_RDATA: begin
                    if (word_done) begin
                        if (state_q == PHY_RDATA) rx_valid_o <= 1'b1;
                        if (last_beat) begin
                            state_q      <= PHY_RECOVER;
                            lat_cnt_q    <= '0;
                            write_done_o <= (state_q == PHY_WDATA);
                        end
                    end
                end
                PHY_RECOVER: begin
                    lat_cnt_q <= lat_cnt_q + 1'b1;
                    if (lat_cnt_q == 4'(RECOVERY_CYCLES - 1)) state_q <= PHY_IDLE;
                end
                default: state_q <= PHY_IDLE;
            endcase
        end
    end

    // R/W#, memory space, linear burst, upper address, reserved, lower address
    always_ff @(posedge clk_i) begin
        if (state_q == PHY_IDLE && trans_valid_i) begin
            trans_q <= trans_i;
            ca_q    <= {!trans_i.write, 1'b0, 1'b1, 29'(trans_i.addr[ADDR_W-2:3]),
                        13'b0, trans_i.addr[2:0]};
        end else if (state_q == PHY_CA && step) begin
            ca_q <= ca_q << 8;
        end

        if (state_q == PHY_RDATA && byte_xfer && !lo_q) rx_hi_q <= hyper_dq_i;
        if (state_q == PHY_RDATA && word_done) begin
            rx_o <= '{data: {rx_hi_q, hyper_dq_i}, last: last_beat};
        end
    end

    always_ff @(posedge clk_i) begin
        hyper_reset_n_o <= rst_n_i;
    end

endmodule

// ==== source/hyper_pkg.sv ====
// Shared widths, bus timing constants and channel structs
// PHY state encoding

package hyper_pkg;

    localparam int NR_CS           = 2;
    localparam int ADDR_W          = 24;  // Word address, top bit picks the chip
    localparam int MAX_BURST       = 16;
    localparam int FIFO_DEPTH      = 16;  // Holds one full read burst
    localparam int CA_BYTES        = 6;
    localparam int LATENCY_CYCLES  = 12;
    localparam int RECOVERY_CYCLES = 4;

    typedef logic [15:0]                    word_t;
    typedef logic [1:0]                     strb_t;
    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [$clog2(MAX_BURST)-1:0]   burst_len_t;  // Beats minus one
    typedef logic [NR_CS-1:0]               cs_t;

    // Write and read request
    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_ax_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        burst_len_t len;
    } hyper_trans_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } tx_beat_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } rx_beat_t;

    typedef enum logic [2:0] {
        PHY_IDLE,
        PHY_CA,
        PHY_LATENCY,
        PHY_WDATA,
        PHY_RDATA,
        PHY_RECOVER
    } phy_state_e;

endpackage

// ==== test/hyper_cases.txt ====
# W word_addr len then per word: strb data
# R word_addr len then per word: expected data
W 000010 0 3 a5c3
R 000010 0 a5c3
W 000100 f 3 a0b0 3 a1b1 3 a2b2 3 a3b3 3 a4b4 3 a5b5 3 a6b6 3 a7b7
 3 a8b8 3 a9b9 3 aaba 3 abbb 3 acbc 3 adbd 3 aebe 3 afbf
R 000100 f a0b0 a1b1 a2b2 a3b3 a4b4 a5b5 a6b6 a7b7
 a8b8 a9b9 aaba abbb acbc adbd aebe afbf
R 000104 7 a4b4 a5b5 a6b6 a7b7 a8b8 a9b9 aaba abbb
# Byte strobes, low byte then high byte
W 000020 0 3 1234
W 000020 0 1 00ab
R 000020 0 12ab
W 000020 0 2 ff00
R 000020 0 ffab
# Same low address on both chips
W 000030 0 3 aaaa
W 800030 0 3 5555
R 000030 0 aaaa
R 800030 0 5555
W 800200 3 3 0102 3 0304 3 0506 3 0708
R 800200 3 0102 0304 0506 0708

// ==== test/hyper_ctrl_assert.sv ====
// Bus and read channel protocol assertions
// Bound into hyper_ctrl

`timescale 1ns/1ps

module hyper_ctrl_assert (
    input logic           clk_i,
    input logic           rst_n_i,
    input hyper_pkg::cs_t cs_n_i,
    input logic           dq_oe_i,
    input logic           rwds_i,
    input logic           r_valid_i,
    input logic           r_ready_i
);

    one_cs_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $countones(~cs_n_i) <= 1)
        else $error("more than one chip select low");

    // Memory drives rwds only while returning read data
    no_dq_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rwds_i |-> !dq_oe_i)
        else $error("dq driven while memory returns read data");

    r_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (r_valid_i && !r_ready_i) |=> r_valid_i)
        else $error("read valid dropped without ready");

endmodule

bind hyper_ctrl hyper_ctrl_assert hyper_ctrl_assert_i (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .cs_n_i    ( hyper_cs_n_o  ),
    .dq_oe_i   ( hyper_dq_oe_o ),
    .rwds_i    ( hyper_rwds_i  ),
    .r_valid_i ( r_valid_o     ),
    .r_ready_i ( r_ready_i     )
);

// ==== test/hyper_ram_model.sv ====
// Behavioral two-chip HyperRAM, single data rate
// Command/address decode, fixed latency, masked writes, reads with rwds high

`timescale 1ns/1ps

module hyper_ram_model (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  hyper_pkg::cs_t cs_n_i,
    input  logic           ck_i,
    input  logic           rwds_i,
    input  logic [7:0]     dq_i,
    output logic           rwds_o,
    output logic [7:0]     dq_o
);

    import hyper_pkg::*;

    localparam int DATA_START = CA_BYTES + LATENCY_CYCLES;

    word_t       mem_cs0 [int];
    word_t       mem_cs1 [int];
    logic        ck_q;
    logic [47:0] ca_q;
    int          cnt_q;
    logic        step;
    logic        is_write;
    logic        chip;
    int          base_addr;

    assign step      = ck_i ^ ck_q;   // Bus clock toggles once per byte
    assign is_write  = !ca_q[47];
    assign chip      = !cs_n_i[1];
    assign base_addr = int'({ca_q[35:16], ca_q[2:0]});

    // Unwritten words show a pattern of chip and full address
    function automatic word_t read_word(input logic sel, input int addr);
        word_t fill;
        fill = word_t'(addr) ^ word_t'(addr >> 16) ^ (sel ? 16'h8000 : 16'h0000);
        if (sel) begin
            return mem_cs1.exists(addr) ? mem_cs1[addr] : fill;
        end
        return mem_cs0.exists(addr) ? mem_cs0[addr] : fill;
    endfunction

    always @(posedge clk_i) begin
        int    next_cnt;
        int    idx;
        word_t wd;
        if (!rst_n_i) begin
            ck_q   <= 1'b0;
            cnt_q  <= 0;
            rwds_o <= 1'b0;
            dq_o   <= 8'h00;
        end else begin
            ck_q     <= ck_i;
            next_cnt = cnt_q + (step ? 1 : 0);
            if (&cs_n_i) begin
                cnt_q  <= 0;
                rwds_o <= 1'b0;
            end else begin
                if (step && cnt_q < CA_BYTES) ca_q <= {ca_q[39:0], dq_i};
                if (step && cnt_q >= DATA_START && is_write && !rwds_i) begin
                    idx = cnt_q - DATA_START;
                    wd  = read_word(chip, base_addr + idx / 2);
                    if (idx % 2 == 0) wd[15:8] = dq_i;  // High byte first
                    else              wd[7:0]  = dq_i;
                    if (chip) mem_cs1[base_addr + idx / 2] = wd;
                    else      mem_cs0[base_addr + idx / 2] = wd;
                end
                cnt_q <= next_cnt;
                // Present the byte for the coming cycle
                rwds_o <= (next_cnt >= DATA_START) && is_write == 1'b0 && cnt_q >= CA_BYTES;
                if (next_cnt >= DATA_START && cnt_q >= CA_BYTES && !is_write) begin
                    idx  = next_cnt - DATA_START;
                    wd   = read_word(chip, base_addr + idx / 2);
                    dq_o <= (idx % 2 == 0) ? wd[15:8] : wd[7:0];
                end
            end
        end
    end

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset source
// 8 ns period, reset held low for 5 cycles

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

    always #4 clk_o = ~clk_o;

endmodule

// ==== test/tb_hyper_ctrl.sv ====
// Testbench top for the HyperBus controller
// Reads cases, drives AXI-style channels, checks read data and responses

`timescale 1ns/1ps

module tb_hyper_ctrl;

    import hyper_pkg::*;

    localparam int CASE_CYCLES =
        (MAX_BURST * 2 + CA_BYTES + LATENCY_CYCLES + RECOVERY_CYCLES + 20) * 4;

    logic       clk;
    logic       rst_n;
    axi_ax_t    aw_i;
    logic       aw_valid_i;
    logic       aw_ready_o;
    axi_w_t     w_i;
    logic       w_valid_i;
    logic       w_ready_o;
    logic       b_valid_o;
    logic       b_ready_i;
    axi_ax_t    ar_i;
    logic       ar_valid_i;
    logic       ar_ready_o;
    axi_r_t     r_o;
    logic       r_valid_o;
    logic       r_ready_i;
    cs_t        hyper_cs_n_o;
    logic       hyper_ck_o;
    logic       hyper_ck_n_o;
    logic       hyper_rwds_o;
    logic       hyper_rwds_i;
    logic       hyper_rwds_oe_o;
    logic [7:0] hyper_dq_o;
    logic [7:0] hyper_dq_i;
    logic       hyper_dq_oe_o;
    logic       hyper_reset_n_o;

    logic       case_wr [$];
    addr_t      case_addr [$];
    burst_len_t case_len [$];
    word_t      case_data [$];
    strb_t      case_strb [$];
    int         cycle_cnt   = 0;
    int         cycle_limit = 0;

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    hyper_ctrl hyper_ctrl_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .aw_i(aw_i), .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
        .w_i(w_i), .w_valid_i(w_valid_i), .w_ready_o(w_ready_o),
        .b_valid_o(b_valid_o), .b_ready_i(b_ready_i),
        .ar_i(ar_i), .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o),
        .r_o(r_o), .r_valid_o(r_valid_o), .r_ready_i(r_ready_i),
        .hyper_cs_n_o(hyper_cs_n_o), .hyper_ck_o(hyper_ck_o), .hyper_ck_n_o(hyper_ck_n_o),
        .hyper_rwds_o(hyper_rwds_o), .hyper_rwds_i(hyper_rwds_i),
        .hyper_rwds_oe_o(hyper_rwds_oe_o),
        .hyper_dq_o(hyper_dq_o), .hyper_dq_i(hyper_dq_i), .hyper_dq_oe_o(hyper_dq_oe_o),
        .hyper_reset_n_o(hyper_reset_n_o)
    );

    // Undriven bus lines read as unknown
    hyper_ram_model ram_i (
        .clk_i(clk), .rst_n_i(rst_n), .cs_n_i(hyper_cs_n_o), .ck_i(hyper_ck_o),
        .rwds_i(hyper_rwds_oe_o ? hyper_rwds_o : 1'bx),
        .dq_i(hyper_dq_oe_o ? hyper_dq_o : 8'hxx),
        .rwds_o(hyper_rwds_i), .dq_o(hyper_dq_i)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("FAILED r_o.last: got %h expected %h", got, exp));
    endtask

    task automatic check_cs(input cs_t got, input cs_t exp);
        if (got !== exp) stop_run($sformatf("FAILED hyper_cs_n_o: got %h expected %h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    function automatic bit gap_now(input bit gaps);
        return gaps && ($urandom_range(3) == 0);
    endfunction

    task automatic load_cases();
        int                fd;
        int                code;
        logic [63:0]       tok;
        logic [8*128-1:0]  line;
        logic [31:0]       a;
        logic [31:0]       l;
        logic [31:0]       s;
        logic [31:0]       d;
        fd = $fopen("test/hyper_cases.txt", "r");
        if (fd == 0) stop_run("cannot open test/hyper_cases.txt");
        forever begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) break;
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "W" || tok == "R") begin
                code = $fscanf(fd, " %h %h", a, l);
                case_wr.push_back(tok == "W");
                case_addr.push_back(addr_t'(a));
                case_len.push_back(burst_len_t'(l));
                for (int i = 0; i <= int'(l); i++) begin
                    if (tok == "W") code = $fscanf(fd, " %h %h", s, d);
                    else            code = $fscanf(fd, " %h", d);
                    case_strb.push_back(strb_t'(s));
                    case_data.push_back(word_t'(d));
                end
            end else begin
                stop_run("unknown operation in cases file");
            end
        end
        $fclose(fd);
    endtask

    task automatic write_burst(input addr_t addr, input burst_len_t len, input int di,
                               input bit gaps);
        int waited;
        aw_i       <= '{addr: addr, len: len};
        aw_valid_i <= 1'b1;
        do @(posedge clk); while (!aw_ready_o);
        aw_valid_i <= 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            while (gap_now(gaps)) begin
                w_valid_i <= 1'b0;
                @(posedge clk);
            end
            w_i <= '{data: case_data[di + i], strb: case_strb[di + i], last: i == int'(len)};
            w_valid_i <= 1'b1;
            do @(posedge clk); while (!w_ready_o);
        end
        w_valid_i <= 1'b0;
        waited = 0;
        forever begin
            b_ready_i <= !gap_now(gaps);
            @(posedge clk);
            if (b_valid_o && b_ready_i) break;
            waited++;
            if (waited > CASE_CYCLES) stop_run("write response never arrived");
        end
        b_ready_i <= 1'b0;
        @(posedge clk);
        if (b_valid_o) stop_run("write response given more than once");
    endtask

    task automatic read_burst(input addr_t addr, input burst_len_t len, input int di,
                              input bit gaps);
        int beat;
        ar_i       <= '{addr: addr, len: len};
        ar_valid_i <= 1'b1;
        do @(posedge clk); while (!ar_ready_o);
        ar_valid_i <= 1'b0;
        beat = 0;
        while (beat <= int'(len)) begin
            r_ready_i <= !gap_now(gaps);
            @(posedge clk);
            if (r_valid_o && r_ready_i) begin
                check_word("r_o.data", r_o.data, case_data[di + beat]);
                check_last(r_o.last, beat == int'(len));
                beat++;
            end
        end
        r_ready_i <= 1'b0;
    endtask

    task automatic run_cases(input bit gaps);
        int di;
        di = 0;
        for (int c = 0; c < case_wr.size(); c++) begin
            if (case_wr[c]) write_burst(case_addr[c], case_len[c], di, gaps);
            else            read_burst(case_addr[c], case_len[c], di, gaps);
            di += int'(case_len[c]) + 1;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_run("timeout, the test did not finish in time");
        end
    end

    // Differential bus clock pair
    always @(posedge clk) begin
        if (rst_n) check_flag("hyper_ck_n_o", hyper_ck_n_o, !hyper_ck_o);
    end

    initial begin
        void'($urandom(32'hd099_8347));
        aw_i       <= '0;
        aw_valid_i <= 1'b0;
        w_i        <= '0;
        w_valid_i  <= 1'b0;
        b_ready_i  <= 1'b0;
        ar_i       <= '0;
        ar_valid_i <= 1'b0;
        r_ready_i  <= 1'b0;
        load_cases();
        // Two passes, without and with handshake gaps
        cycle_limit = 2 * case_wr.size() * CASE_CYCLES + 20;

        wait (rst_n === 1'b1);
        @(posedge clk);
        check_cs(hyper_cs_n_o, '1);
        check_flag("hyper_dq_oe_o", hyper_dq_oe_o, 1'b0);
        check_flag("hyper_rwds_oe_o", hyper_rwds_oe_o, 1'b0);
        check_flag("b_valid_o", b_valid_o, 1'b0);
        check_flag("r_valid_o", r_valid_o, 1'b0);
        check_flag("hyper_reset_n_o", hyper_reset_n_o, 1'b0);
        @(posedge clk);
        check_flag("hyper_reset_n_o", hyper_reset_n_o, 1'b1);

        run_cases(1'b0);
        run_cases(1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
